// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= riscv_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/frontend_checker.sv ====
`timescale 1ns/1ps

module frontend_checker
	import rv_isa_pkg::*, frontend_pkg::*;
(
	input logic    clk,
	input logic    reset,
	input logic    out_valid,
	input logic    out_ready,
	input addr_t   out_pc,
	input inst_t   out_inst,
	input xdata_t  imm,
	input alu_op_e alu_op,
	input logic    mem_wen,
	input logic    mem_ren,
	input logic    reg_wen,
	input logic    illegal,
	input addr_t   imem_addr
);

	int unsigned fail_count = 0; // count of failed assertions

	// stalled output must not move
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_pc) && $stable(out_inst)
			&& $stable(imm) && $stable(alu_op)
			&& $stable({mem_wen, mem_ren, reg_wen, illegal})))
		else begin
			fail_count++;
			$error("decode outputs changed while stalled");
		end

	a_ctrl_idle: assert property (@(posedge clk) disable iff (reset)
		!out_valid |-> !(mem_wen || mem_ren || reg_wen || illegal))
		else begin
			fail_count++;
			$error("control output high without out_valid");
		end

	a_word_aligned: assert property (@(posedge clk) disable iff (reset)
		imem_addr[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("imem_addr not word aligned");
		end

endmodule

bind riscv_frontend frontend_checker frontend_checker_i (
	.clk       (clk),
	.reset     (reset),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_pc    (out_pc),
	.out_inst  (out_inst),
	.imm       (imm),
	.alu_op    (alu_op),
	.mem_wen   (mem_wen),
	.mem_ren   (mem_ren),
	.reg_wen   (reg_wen),
	.illegal   (illegal),
	.imem_addr (imem_addr)
);

// ==== bench/frontend_tb.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module frontend_tb
	import rv_isa_pkg::*, frontend_pkg::*;
();

	typedef struct packed {
		reg_idx_t  rs1;
		reg_idx_t  rs2;
		reg_idx_t  rd;
		xdata_t    imm;
		src1_sel_e src1_sel;
		src2_sel_e src2_sel;
		alu_op_e   alu_op;
		logic      mem_wen;
		logic      mem_ren;
		logic      wb_sel;
		logic      reg_wen;
		logic      illegal;
	} exp_t;

	logic      clk;
	logic      gen_reset;
	logic      soft_reset;
	logic      reset;
	addr_t     imem_addr;
	inst_t     imem_rdata;
	logic      resolve_valid;
	addr_t     resolve_pc;
	logic      out_valid;
	logic      out_ready;
	addr_t     out_pc;
	inst_t     out_inst;
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	reg_idx_t  rd;
	xdata_t    imm;
	src1_sel_e src1_sel;
	src2_sel_e src2_sel;
	alu_op_e   alu_op;
	logic      mem_wen;
	logic      mem_ren;
	logic      wb_sel;
	logic      reg_wen;
	logic      illegal;

	inst_t       imem [addr_t]; // sparse program memory
	int          mem_gen = 0;    // bumped on every program load
	logic [15:0] lfsr_state;
	inst_t       prog [$];

	tb_clock_gen tb_clock_gen_i (.clk(clk), .reset(gen_reset));

	assign reset = gen_reset || soft_reset;

	riscv_frontend riscv_frontend_i (
		.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.resolve_valid(resolve_valid), .resolve_pc(resolve_pc),
		.out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_inst(out_inst),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .src1_sel(src1_sel),
		.src2_sel(src2_sel), .alu_op(alu_op), .mem_wen(mem_wen), .mem_ren(mem_ren),
		.wb_sel(wb_sel), .reg_wen(reg_wen), .illegal(illegal)
	);

	// unloaded words are addi x0,x0,imm with imm folded from the address
	function automatic inst_t read_word(addr_t a);
		logic [11:0] h;
		if (imem.exists(a))
			return imem[a];
		h = a[11:0] ^ a[23:12] ^ a[35:24] ^ a[47:36] ^ a[59:48] ^ {8'b0, a[63:60]};
		return {h, 13'b0, 7'b001_0011};
	endfunction

	always @(imem_addr or mem_gen) imem_rdata = read_word(imem_addr); // combinational port

	always @(negedge clk) begin
		if (riscv_frontend_i.frontend_checker_i.fail_count != 0)
			fail_now("assertion failure in the bound checker");
	end

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t s2, reg_idx_t s1,
			funct3_t f3, reg_idx_t d, logic [6:0] op);
		return {f7, s2, s1, f3, d, op};
	endfunction

	function automatic inst_t enc_i(logic [11:0] i, reg_idx_t s1, funct3_t f3,
			reg_idx_t d, logic [6:0] op);
		return {i, s1, f3, d, op};
	endfunction

	function automatic inst_t enc_s(logic [11:0] i, reg_idx_t s2, reg_idx_t s1, funct3_t f3);
		return {i[11:5], s2, s1, f3, i[4:0], 7'b010_0011};
	endfunction

	function automatic inst_t enc_b(logic [12:0] i, reg_idx_t s2, reg_idx_t s1, funct3_t f3);
		return {i[12], i[10:5], s2, s1, f3, i[4:1], i[11], 7'b110_0011};
	endfunction

	function automatic inst_t enc_j(logic [20:0] i, reg_idx_t d);
		return {i[20], i[10:1], i[11], i[19:12], d, 7'b110_1111};
	endfunction

	// alu operation straight from the ISA encoding tables
	function automatic alu_op_e ref_alu(inst_t i);
		logic [6:0] op;
		funct3_t    f3;
		logic       w;
		alu_op_e    base [8];
		alu_op_e    brn [8];
		op   = i[6:0];
		f3   = i[14:12];
		w    = (op == OP_32) || (op == OP_IMM_32);
		base = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
		brn  = '{ALU_EQ, ALU_NE, ALU_NONE, ALU_NONE, ALU_SLT, ALU_GE, ALU_SLTU, ALU_GEU};
		if (op == OP || op == OP_32) begin
			if (i[25]) begin
				if (i[30] || f3 == 3'd2 || (w && (f3 == 3'd1 || f3 == 3'd3)))
					return ALU_NONE; // mulhsu and missing word forms
				case (f3)
					3'd0: return w ? ALU_MULW : ALU_MUL;
					3'd1: return ALU_MULH;
					3'd3: return ALU_MULHU;
					3'd4: return w ? ALU_DIVW : ALU_DIV;
					3'd5: return w ? ALU_DIVUW : ALU_DIVU;
					3'd6: return w ? ALU_REMW : ALU_REM;
					default: return w ? ALU_REMUW : ALU_REMU;
				endcase
			end
			if (f3 == 3'd0)
				return i[30] ? (w ? ALU_SUBW : ALU_SUB) : (w ? ALU_ADDW : ALU_ADD);
			if (f3 == 3'd5)
				return i[30] ? (w ? ALU_SRAW : ALU_SRA) : (w ? ALU_SRLW : ALU_SRL);
			if (i[30] || (w && f3 != 3'd1))
				return ALU_NONE;
			return w ? ALU_SLLW : base[f3];
		end
		if (op == OP_IMM || op == OP_IMM_32) begin
			if (f3 == 3'd5)
				return i[30] ? (w ? ALU_SRAW : ALU_SRA) : (w ? ALU_SRLW : ALU_SRL);
			if (!w)
				return base[f3];
			return (f3 == 3'd0) ? ALU_ADDW : (f3 == 3'd1) ? ALU_SLLW : ALU_NONE;
		end
		if (op == BRANCH)
			return brn[f3];
		if (op == LOAD || op == STORE || op == JAL || op == JALR || op == LUI || op == AUIPC)
			return ALU_ADD;
		return ALU_NONE;
	endfunction

	function automatic exp_t ref_decode(inst_t i);
		exp_t       e;
		logic [6:0] op;
		op = i[6:0];
		e  = '0;
		e.rs1      = i[19:15];
		e.rs2      = i[24:20];
		e.rd       = i[11:7];
		e.alu_op   = ref_alu(i);
		e.illegal  = (e.alu_op == ALU_NONE);
		e.imm      = {{52{i[31]}}, i[31:20]};
		e.src1_sel = REG1;
		e.src2_sel = REG2;
		if (op == OP || op == OP_32) begin
			e.reg_wen = 1'b1;
		end else if (op == OP_IMM || op == OP_IMM_32 || op == LOAD) begin
			e.src2_sel = IMM;
			e.reg_wen  = 1'b1;
			e.mem_ren  = (op == LOAD);
			e.wb_sel   = (op == LOAD);
		end else if (op == STORE) begin
			e.imm      = {{52{i[31]}}, i[31:25], i[11:7]};
			e.src2_sel = IMM;
			e.mem_wen  = 1'b1;
		end else if (op == BRANCH) begin
			e.imm = {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
		end else if (op == JAL || op == JALR) begin
			if (op == JAL)
				e.imm = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
			e.src1_sel = PC;
			e.src2_sel = FOUR;
			e.reg_wen  = 1'b1;
		end else if (op == LUI || op == AUIPC) begin
			e.imm      = {{32{i[31]}}, i[31:12], 12'b0};
			e.src1_sel = (op == LUI) ? ZERO : PC;
			e.src2_sel = IMM;
			e.reg_wen  = 1'b1;
		end
		if (e.illegal) begin
			e.mem_wen = 1'b0;
			e.mem_ren = 1'b0;
			e.reg_wen = 1'b0;
		end
		return e;
	endfunction

	task automatic fail_now(string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic compare_addr(string name, addr_t got, addr_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_data(string name, xdata_t got, xdata_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_inst(string name, inst_t got, inst_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_reg(string name, reg_idx_t got, reg_idx_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_src1(string name, src1_sel_e got, src1_sel_e exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_src2(string name, src2_sel_e got, src2_sel_e exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_alu_op(string name, alu_op_e got, alu_op_e exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_ctrl(string name, logic got, logic exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// returns at the falling edge before the transfer while outputs are still stable
	task automatic next_out(logic use_lfsr);
		int n;
		n = 0;
		forever begin
			@(negedge clk);
			out_ready = use_lfsr ? lfsr_bit() : 1'b1;
			if (out_valid && out_ready)
				return;
			n++;
			if (n > 60)
				fail_now("timeout waiting for an instruction at the out port");
		end
	endtask

	task automatic expect_out(addr_t pc, logic use_lfsr);
		exp_t e;
		e = ref_decode(read_word(pc));
		next_out(use_lfsr);
		compare_addr("out_pc", out_pc, pc);
		compare_inst("out_inst", out_inst, read_word(pc));
		compare_reg("rs1", rs1, e.rs1);
		compare_reg("rs2", rs2, e.rs2);
		compare_reg("rd", rd, e.rd);
		compare_ctrl("illegal", illegal, e.illegal);
		compare_ctrl("mem_wen", mem_wen, e.mem_wen);
		compare_ctrl("mem_ren", mem_ren, e.mem_ren);
		compare_ctrl("reg_wen", reg_wen, e.reg_wen);
		if (!e.illegal) begin
			compare_data("imm", imm, e.imm);
			compare_src1("src1_sel", src1_sel, e.src1_sel);
			compare_src2("src2_sel", src2_sel, e.src2_sel);
			compare_alu_op("alu_op", alu_op, e.alu_op);
			compare_ctrl("wb_sel", wb_sel, e.wb_sel);
		end
	endtask

	task automatic restart();
		@(negedge clk);
		soft_reset    = 1'b1;
		out_ready     = 1'b0;
		resolve_valid = 1'b0;
		repeat (2) @(negedge clk);
		soft_reset = 1'b0;
	endtask

	// loads prog at the reset PC and expects it back in order
	task automatic run_linear(logic use_lfsr);
		imem.delete();
		foreach (prog[k])
			imem[`RESET_PC + 64'(4 * k)] = prog[k];
		mem_gen++;
		restart();
		foreach (prog[k])
			expect_out(`RESET_PC + 64'(4 * k), use_lfsr);
	endtask

	task automatic build_alu_program();
		prog.delete();
		for (int k = 0; k < 8; k++) begin
			prog.push_back(enc_r(7'h00, 5'(k + 3), 5'(k * 5), 3'(k), 5'(k * 7), OP));
			prog.push_back(enc_r(7'h01, 5'(k * 3), 5'(k + 9), 3'(k), 5'(k + 1), OP));
			prog.push_back(enc_r(7'h01, 5'(k), 5'(k + 2), 3'(k), 5'(k + 4), OP_32));
			prog.push_back(enc_i(12'(k * 683), 5'(k + 11), 3'(k), 5'(k * 3), OP_IMM));
		end
		prog.push_back(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4, OP));    // sub
		prog.push_back(enc_r(7'h20, 5'd5, 5'd6, 3'd5, 5'd7, OP));    // sra
		prog.push_back(enc_r(7'h00, 5'd8, 5'd9, 3'd0, 5'd10, OP_32)); // addw
		prog.push_back(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3, OP_32));  // subw
		prog.push_back(enc_r(7'h00, 5'd4, 5'd5, 3'd1, 5'd6, OP_32));  // sllw
		prog.push_back(enc_r(7'h00, 5'd7, 5'd8, 3'd5, 5'd9, OP_32));  // srlw
		prog.push_back(enc_r(7'h20, 5'd1, 5'd3, 3'd5, 5'd5, OP_32));  // sraw
		prog.push_back(enc_i(12'h413, 5'd4, 3'd5, 5'd6, OP_IMM));     // srai
		prog.push_back(enc_i(12'h800, 5'd7, 3'd0, 5'd8, OP_IMM_32));  // addiw
		prog.push_back(enc_i(12'h01f, 5'd9, 3'd1, 5'd10, OP_IMM_32)); // slliw
		prog.push_back(enc_i(12'h405, 5'd11, 3'd5, 5'd12, OP_IMM_32)); // sraiw
	endtask

	task automatic test_straight_line();
		build_alu_program();
		run_linear(1'b0);
	endtask

	task automatic test_memory_and_upper();
		prog.delete();
		prog.push_back(enc_i(12'hff8, 5'd2, 3'd3, 5'd5, LOAD));  // ld -8
		prog.push_back(enc_i(12'h7fc, 5'd3, 3'd2, 5'd6, LOAD));  // lw
		prog.push_back(enc_i(12'h801, 5'd4, 3'd4, 5'd7, LOAD));  // lbu
		prog.push_back(enc_s(12'hf81, 5'd8, 5'd2, 3'd0));        // sb
		prog.push_back(enc_s(12'h07e, 5'd9, 5'd2, 3'd3));        // sd
		prog.push_back({20'hfffff, 5'd10, 7'(LUI)});
		prog.push_back({20'h12345, 5'd11, 7'(LUI)});
		prog.push_back({20'h80000, 5'd12, 7'(AUIPC)});
		run_linear(1'b0);
	endtask

	task automatic test_jal();
		imem.delete();
		imem[`RESET_PC]         = enc_i(12'd1, 5'd0, 3'd0, 5'd1, OP_IMM);
		imem[`RESET_PC + 64'h4]  = enc_j(21'h000040, 5'd1);   // forward to +0x44
		imem[`RESET_PC + 64'h44] = enc_i(12'd2, 5'd1, 3'd0, 5'd2, OP_IMM);
		imem[`RESET_PC + 64'h48] = enc_j(21'h1fffdc, 5'd0);   // back to +0x24
		mem_gen++;
		restart();
		expect_out(`RESET_PC, 1'b0);
		expect_out(`RESET_PC + 64'h4, 1'b0);
		expect_out(`RESET_PC + 64'h44, 1'b0);
		expect_out(`RESET_PC + 64'h48, 1'b0);
		expect_out(`RESET_PC + 64'h24, 1'b0);
		expect_out(`RESET_PC + 64'h28, 1'b0);
	endtask

	task automatic hold_until_resolve(addr_t target);
		repeat (10) begin
			@(negedge clk);
			out_ready = 1'b1;
			if (out_valid)
				fail_now("instruction left the front end before the branch was resolved");
		end
		@(negedge clk);
		resolve_valid = 1'b1;
		resolve_pc    = target;
		@(negedge clk);
		resolve_valid = 1'b0;
	endtask

	task automatic test_resolve();
		imem.delete();
		imem[`RESET_PC]          = enc_b(13'h0010, 5'd2, 5'd1, 3'd0); // beq
		imem[`RESET_PC + 64'h100] = enc_i(12'h008, 5'd5, 3'd0, 5'd1, JALR);
		imem[`RESET_PC + 64'h200] = enc_i(12'h7ff, 5'd3, 3'd0, 5'd4, OP_IMM);
		mem_gen++;
		restart();
		expect_out(`RESET_PC, 1'b0);
		hold_until_resolve(`RESET_PC + 64'h100);
		expect_out(`RESET_PC + 64'h100, 1'b0);
		hold_until_resolve(`RESET_PC + 64'h200);
		expect_out(`RESET_PC + 64'h200, 1'b0);
		expect_out(`RESET_PC + 64'h204, 1'b0);
	endtask

	task automatic test_back_pressure();
		build_alu_program();
		run_linear(1'b1);
	endtask

	task automatic test_illegal();
		prog.delete();
		prog.push_back(32'hffff_ffff);                              // opcode 7f
		prog.push_back(enc_i(12'd5, 5'd1, 3'd0, 5'd2, OP_IMM));
		prog.push_back(32'h0000_010b);                              // custom-0
		prog.push_back(enc_r(7'h20, 5'd1, 5'd2, 3'd4, 5'd3, OP));   // no such op
		prog.push_back(enc_i(12'd6, 5'd1, 3'd0, 5'd2, OP_IMM));
		run_linear(1'b0);
	endtask

	initial begin
		int n;
		soft_reset    = 1'b0;
		out_ready     = 1'b0;
		resolve_valid = 1'b0;
		resolve_pc    = '0;
		lfsr_state    = 16'd63848;
		mem_gen       = 1;
		n = 0;
		while (gen_reset !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > 20)
				fail_now("reset from the clock generator never released");
		end
		test_straight_line();
		test_memory_and_upper();
		test_jal();
		test_resolve();
		test_back_pressure();
		test_illegal();
		if (riscv_frontend_i.frontend_checker_i.fail_count != 0) begin
			fail_now("assertion failure in the bound checker");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== riscv_frontend.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/frontend_pkg.sv
verilog/fetch_if.sv
verilog/if_stage.sv
verilog/ctrl_decoder.sv
verilog/id_stage.sv
verilog/riscv_frontend.sv
bench/tb_clock_gen.sv
bench/frontend_checker.sv
bench/frontend_tb.sv

// ==== verilog/ctrl_decoder.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module ctrl_decoder
	import rv_isa_pkg::*, frontend_pkg::*;
(
	input  inst_t     inst,
	output reg_idx_t  rs1,
	output reg_idx_t  rs2,
	output reg_idx_t  rd,
	output xdata_t    imm,
	output src1_sel_e src1_sel,
	output src2_sel_e src2_sel,
	output alu_op_e   alu_op,
	output logic      mem_wen,
	output logic      mem_ren,
	output logic      wb_sel,
	output logic      reg_wen,
	output logic      is_jal,
	output logic      needs_resolve,
	output logic      illegal,
	output addr_t     jal_offset
);

	opcode_e opcode;
	funct3_t funct3;
	logic    alt;   // bit 30, sub/sra
	logic    mext;  // bit 25, M extension
	xdata_t  imm_i;
	xdata_t  imm_s;
	xdata_t  imm_b;
	xdata_t  imm_u;
	xdata_t  imm_j;
	logic    known_op;
	logic    mem_wen_raw;
	logic    mem_ren_raw;
	logic    reg_wen_raw;
	logic    jal_raw;
	logic    resolve_raw;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign alt    = inst[30];
	assign mext   = inst[25];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign rd     = inst[11:7];

	assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign jal_offset = imm_j;

	// format and control selection
	always_comb begin
		imm         = imm_i;
		src1_sel    = REG1;
		src2_sel    = REG2;
		known_op    = 1'b1;
		mem_wen_raw = 1'b0;
		mem_ren_raw = 1'b0;
		wb_sel      = 1'b0;
		reg_wen_raw = 1'b0;
		jal_raw     = 1'b0;
		resolve_raw = 1'b0;
		case (opcode)
			OP, OP_32: begin
				reg_wen_raw = 1'b1;
			end
			OP_IMM, OP_IMM_32, LOAD: begin
				src2_sel    = IMM;
				reg_wen_raw = 1'b1;
				mem_ren_raw = (opcode == LOAD);
				wb_sel      = (opcode == LOAD); // writeback from memory
			end
			STORE: begin
				imm         = imm_s;
				src2_sel    = IMM;
				mem_wen_raw = 1'b1;
			end
			BRANCH: begin
				imm         = imm_b;
				resolve_raw = 1'b1;
			end
			JAL: begin
				imm         = imm_j;
				src1_sel    = PC;
				src2_sel    = FOUR; // link value pc+4
				reg_wen_raw = 1'b1;
				jal_raw     = 1'b1;
			end
			JALR: begin
				src1_sel    = PC;
				src2_sel    = FOUR;
				reg_wen_raw = 1'b1;
				resolve_raw = 1'b1; // target needs rs1, resolved in back end
			end
			LUI: begin
				imm         = imm_u;
				src1_sel    = ZERO;
				src2_sel    = IMM;
				reg_wen_raw = 1'b1;
			end
			AUIPC: begin
				imm         = imm_u;
				src1_sel    = PC;
				src2_sel    = IMM;
				reg_wen_raw = 1'b1;
			end
			default: known_op = 1'b0;
		endcase
	end

	// ALU operation from funct3, bit 30 and bit 25
	always_comb begin
		alu_op = ALU_NONE;
		case (opcode)
			OP: begin
				if (mext && !alt) begin
					case (funct3)
						3'b000: alu_op = ALU_MUL;
						3'b001: alu_op = ALU_MULH;
						3'b011: alu_op = ALU_MULHU;
						3'b100: alu_op = ALU_DIV;
						3'b101: alu_op = ALU_DIVU;
						3'b110: alu_op = ALU_REM;
						3'b111: alu_op = ALU_REMU;
						default: alu_op = ALU_NONE; // mulhsu not supported
					endcase
				end else if (!mext) begin
					case (funct3)
						3'b000: alu_op = alt ? ALU_SUB : ALU_ADD;
						3'b101: alu_op = alt ? ALU_SRA : ALU_SRL;
						3'b001: alu_op = alt ? ALU_NONE : ALU_SLL;
						3'b010: alu_op = alt ? ALU_NONE : ALU_SLT;
						3'b011: alu_op = alt ? ALU_NONE : ALU_SLTU;
						3'b100: alu_op = alt ? ALU_NONE : ALU_XOR;
						3'b110: alu_op = alt ? ALU_NONE : ALU_OR;
						3'b111: alu_op = alt ? ALU_NONE : ALU_AND;
						default: alu_op = ALU_NONE;
					endcase
				end
			end
			OP_32: begin
				if (mext && !alt) begin
					case (funct3)
						3'b000: alu_op = ALU_MULW;
						3'b100: alu_op = ALU_DIVW;
						3'b101: alu_op = ALU_DIVUW;
						3'b110: alu_op = ALU_REMW;
						3'b111: alu_op = ALU_REMUW;
						default: alu_op = ALU_NONE;
					endcase
				end else if (!mext) begin
					case (funct3)
						3'b000: alu_op = alt ? ALU_SUBW : ALU_ADDW;
						3'b001: alu_op = alt ? ALU_NONE : ALU_SLLW;
						3'b101: alu_op = alt ? ALU_SRAW : ALU_SRLW;
						default: alu_op = ALU_NONE;
					endcase
				end
			end
			OP_IMM: begin
				case (funct3)
					3'b000: alu_op = ALU_ADD;
					3'b001: alu_op = ALU_SLL;
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b101: alu_op = alt ? ALU_SRA : ALU_SRL;
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
					default: alu_op = ALU_NONE;
				endcase
			end
			OP_IMM_32: begin
				case (funct3)
					3'b000: alu_op = ALU_ADDW;
					3'b001: alu_op = ALU_SLLW;
					3'b101: alu_op = alt ? ALU_SRAW : ALU_SRLW;
					default: alu_op = ALU_NONE;
				endcase
			end
			BRANCH: begin
				case (funct3)
					3'b000: alu_op = ALU_EQ;
					3'b001: alu_op = ALU_NE;
					3'b100: alu_op = ALU_SLT;  // blt
					3'b101: alu_op = ALU_GE;
					3'b110: alu_op = ALU_SLTU; // bltu
					3'b111: alu_op = ALU_GEU;
					default: alu_op = ALU_NONE;
				endcase
			end
			LOAD, STORE, JAL, JALR, LUI, AUIPC: alu_op = ALU_ADD;
			default: alu_op = ALU_NONE;
		endcase
	end

	assign illegal       = !known_op || (alu_op == ALU_NONE);
	assign mem_wen       = mem_wen_raw && !illegal;
	assign mem_ren       = mem_ren_raw && !illegal;
	assign reg_wen       = reg_wen_raw && !illegal;
	assign is_jal        = jal_raw && !illegal;
	assign needs_resolve = resolve_raw && !illegal; // illegal falls through at pc+4

endmodule

// ==== verilog/fetch_if.sv ====
`timescale 1ns/1ps

// fetch to decode handoff, one instruction per valid/ready transfer
interface fetch_if
	import rv_isa_pkg::*, frontend_pkg::*;
();

	logic  valid;
	logic  ready;
	addr_t pc;
	inst_t inst;

	modport fetch (
		output valid,
		output pc,
		output inst,
		input  ready
	);

	modport decode (
		input  valid,
		input  pc,
		input  inst,
		output ready
	);

endinterface

// ==== verilog/frontend_config.svh ====
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// machine word width, RV64
`define XLEN 64

// instruction width, no compressed forms
`define ILEN 32

// first fetch address after reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

// ==== verilog/frontend_pkg.sv ====
`include "frontend_config.svh"

package frontend_pkg;

	typedef logic [`XLEN-1:0] addr_t;
	typedef logic [`XLEN-1:0] xdata_t;

	// numbering shared with the execute stage, keep in this order
	typedef enum logic [4:0] {
		ALU_ADD, ALU_ADDW, ALU_SLL, ALU_SLLW,
		ALU_SRA, ALU_SRAW, ALU_SRL, ALU_SRLW,
		ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLTU, ALU_EQ, ALU_NE, ALU_GE,
		ALU_GEU, ALU_SUB, ALU_SUBW, ALU_MUL,
		ALU_MULH, ALU_MULHU, ALU_MULW, ALU_DIV,
		ALU_DIVU, ALU_DIVW, ALU_DIVUW, ALU_REM,
		ALU_REMU, ALU_REMUW, ALU_REMW, ALU_NONE
	} alu_op_e;

	// first ALU operand
	typedef enum logic [1:0] {
		REG1,
		ZERO,
		PC
	} src1_sel_e;

	// second ALU operand
	typedef enum logic [1:0] {
		REG2,
		IMM,
		FOUR
	} src2_sel_e;

	typedef enum logic {
		RUN,
		WAIT_RESOLVE // branch or jalr in flight
	} fetch_state_e;

endpackage

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps

module id_stage
	import rv_isa_pkg::*, frontend_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	fetch_if.decode   fetch,
	output logic      jump_valid,
	output logic      wait_resolve,
	output addr_t     jump_pc,
	input  logic      out_ready,
	output logic      out_valid,
	output addr_t     out_pc,
	output inst_t     out_inst,
	output reg_idx_t  rs1,
	output reg_idx_t  rs2,
	output reg_idx_t  rd,
	output xdata_t    imm,
	output src1_sel_e src1_sel,
	output src2_sel_e src2_sel,
	output alu_op_e   alu_op,
	output logic      mem_wen,
	output logic      mem_ren,
	output logic      wb_sel,
	output logic      reg_wen,
	output logic      illegal
);

	reg_idx_t  dec_rs1;
	reg_idx_t  dec_rs2;
	reg_idx_t  dec_rd;
	xdata_t    dec_imm;
	src1_sel_e dec_src1_sel;
	src2_sel_e dec_src2_sel;
	alu_op_e   dec_alu_op;
	logic      dec_mem_wen;
	logic      dec_mem_ren;
	logic      dec_wb_sel;
	logic      dec_reg_wen;
	logic      dec_is_jal;
	logic      dec_needs_resolve;
	logic      dec_illegal;
	addr_t     dec_jal_offset;
	logic      transfer;

	ctrl_decoder ctrl_decoder_i (
		.inst          (fetch.inst),
		.rs1           (dec_rs1),
		.rs2           (dec_rs2),
		.rd            (dec_rd),
		.imm           (dec_imm),
		.src1_sel      (dec_src1_sel),
		.src2_sel      (dec_src2_sel),
		.alu_op        (dec_alu_op),
		.mem_wen       (dec_mem_wen),
		.mem_ren       (dec_mem_ren),
		.wb_sel        (dec_wb_sel),
		.reg_wen       (dec_reg_wen),
		.is_jal        (dec_is_jal),
		.needs_resolve (dec_needs_resolve),
		.illegal       (dec_illegal),
		.jal_offset    (dec_jal_offset)
	);

	assign fetch.ready  = !out_valid || out_ready; // slot empty or draining
	assign transfer     = fetch.valid && fetch.ready;
	assign jump_valid   = transfer && dec_is_jal;
	assign jump_pc      = fetch.pc + dec_jal_offset;
	assign wait_resolve = transfer && dec_needs_resolve;

	// control state, cleared whenever the slot empties
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			mem_wen   <= 1'b0;
			mem_ren   <= 1'b0;
			reg_wen   <= 1'b0;
			illegal   <= 1'b0;
		end else if (fetch.ready) begin
			out_valid <= fetch.valid;
			mem_wen   <= fetch.valid && dec_mem_wen;
			mem_ren   <= fetch.valid && dec_mem_ren;
			reg_wen   <= fetch.valid && dec_reg_wen;
			illegal   <= fetch.valid && dec_illegal;
		end
	end

	// payload, loaded on a transfer only
	always_ff @(posedge clk) begin
		if (transfer) begin
			out_pc   <= fetch.pc;
			out_inst <= fetch.inst;
			rs1      <= dec_rs1;
			rs2      <= dec_rs2;
			rd       <= dec_rd;
			imm      <= dec_imm;
			src1_sel <= dec_src1_sel;
			src2_sel <= dec_src2_sel;
			alu_op   <= dec_alu_op;
			wb_sel   <= dec_wb_sel;
		end
	end

endmodule

// ==== verilog/if_stage.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module if_stage
	import rv_isa_pkg::*, frontend_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	fetch_if.fetch fetch,
	output addr_t  imem_addr,
	input  inst_t  imem_rdata,
	input  logic   jump_valid,
	input  logic   wait_resolve,
	input  addr_t  jump_pc,
	input  logic   resolve_valid,
	input  addr_t  resolve_pc
);

	fetch_state_e state_q;
	fetch_state_e state_d;
	addr_t        pc_q;
	addr_t        pc_d;
	logic         transfer;

	assign imem_addr   = pc_q;
	assign fetch.valid = (state_q == RUN); // no fetch while waiting for resolve
	assign fetch.pc    = pc_q;
	assign fetch.inst  = imem_rdata; // combinational memory port
	assign transfer    = fetch.valid && fetch.ready;

	always_comb begin
		state_d = state_q;
		pc_d    = pc_q;
		case (state_q)
			RUN: begin
				if (transfer) begin
					if (wait_resolve) begin
						state_d = WAIT_RESOLVE; // pc kept, overwritten on resolve
					end else if (jump_valid) begin
						pc_d = jump_pc; // jal target, no bubble
					end else begin
						pc_d = pc_q + 64'd4;
					end
				end
			end
			WAIT_RESOLVE: begin
				if (resolve_valid) begin
					pc_d    = resolve_pc;
					state_d = RUN;
				end
			end
			default: state_d = RUN;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= RUN;
			pc_q    <= `RESET_PC;
		end else begin
			state_q <= state_d;
			pc_q    <= pc_d;
		end
	end

endmodule

// ==== verilog/riscv_frontend.sv ====
`timescale 1ns/1ps

module riscv_frontend
	import rv_isa_pkg::*, frontend_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	output addr_t     imem_addr,
	input  inst_t     imem_rdata,
	input  logic      resolve_valid,
	input  addr_t     resolve_pc,
	output logic      out_valid,
	input  logic      out_ready,
	output addr_t     out_pc,
	output inst_t     out_inst,
	output reg_idx_t  rs1,
	output reg_idx_t  rs2,
	output reg_idx_t  rd,
	output xdata_t    imm,
	output src1_sel_e src1_sel,
	output src2_sel_e src2_sel,
	output alu_op_e   alu_op,
	output logic      mem_wen,
	output logic      mem_ren,
	output logic      wb_sel,
	output logic      reg_wen,
	output logic      illegal
);

	logic  jump_valid;
	logic  wait_resolve;
	addr_t jump_pc;

	fetch_if fetch_bus ();

	if_stage if_stage_i (
		.clk           (clk),
		.reset         (reset),
		.fetch         (fetch_bus.fetch),
		.imem_addr     (imem_addr),
		.imem_rdata    (imem_rdata),
		.jump_valid    (jump_valid),
		.wait_resolve  (wait_resolve),
		.jump_pc       (jump_pc),
		.resolve_valid (resolve_valid),
		.resolve_pc    (resolve_pc)
	);

	id_stage id_stage_i (
		.clk          (clk),
		.reset        (reset),
		.fetch        (fetch_bus.decode),
		.jump_valid   (jump_valid),
		.wait_resolve (wait_resolve),
		.jump_pc      (jump_pc),
		.out_ready    (out_ready),
		.out_valid    (out_valid),
		.out_pc       (out_pc),
		.out_inst     (out_inst),
		.rs1          (rs1),
		.rs2          (rs2),
		.rd           (rd),
		.imm          (imm),
		.src1_sel     (src1_sel),
		.src2_sel     (src2_sel),
		.alu_op       (alu_op),
		.mem_wen      (mem_wen),
		.mem_ren      (mem_ren),
		.wb_sel       (wb_sel),
		.reg_wen      (reg_wen),
		.illegal      (illegal)
	);

endmodule

// ==== verilog/rv_isa_pkg.sv ====
`include "frontend_config.svh"

package rv_isa_pkg;

	typedef logic [`ILEN-1:0] inst_t;    // one raw instruction word
	typedef logic [4:0]       reg_idx_t; // x0..x31
	typedef logic [2:0]       funct3_t;

	// major opcodes handled by the front end
	typedef enum logic [6:0] {
		OP        = 7'b011_0011,
		OP_32     = 7'b011_1011,
		OP_IMM    = 7'b001_0011,
		OP_IMM_32 = 7'b001_1011,
		LOAD      = 7'b000_0011,
		STORE     = 7'b010_0011,
		BRANCH    = 7'b110_0011,
		JAL       = 7'b110_1111,
		JALR      = 7'b110_0111,
		LUI       = 7'b011_0111,
		AUIPC     = 7'b001_0111
	} opcode_e;

endpackage
